// File: switch_macros.svh
// Size constants for the 4-port packet switch, shared by design and testbench.
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

`define SW_PORTS       4
`define SW_PORT_BITS   2
`define SW_WORD_W      16
`define SW_FIFO_DEPTH  32
`define SW_MAX_PKT     8

// A packet started just before pause rises still fits in the FIFO.
`define SW_PAUSE_LEVEL (`SW_FIFO_DEPTH - `SW_MAX_PKT)

`endif

// File: switch_pkg.sv
// Shared data types and the control state encoding of the packet switch.
`default_nettype none

`include "switch_macros.svh"

package switch_pkg;

    typedef logic [`SW_WORD_W-1:0]    word_t;
    typedef logic [`SW_PORT_BITS-1:0] port_t;
    typedef logic [`SW_PORTS-1:0]     port_mask_t;

    // Fill count from empty up to a completely full FIFO.
    typedef logic [$clog2(`SW_FIFO_DEPTH + 1)-1:0] level_t;

    typedef logic [$clog2(`SW_FIFO_DEPTH)-1:0] pkt_cnt_t;  // Complete packets held.

    typedef enum logic {
        IDLE,
        SEND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: in_port_fifo.sv
// Input port FIFO that buffers framed words and offers only complete packets.
`timescale 1ns/1ps
`default_nettype none

`include "switch_macros.svh"

module in_port_fifo (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wr_vld,
    input  wire                       wr_sop,
    input  wire                       wr_eop,
    input  wire switch_pkg::word_t    wr_data,
    input  wire                       pop,
    output switch_pkg::word_t         head_word,
    output logic                      head_eop,
    output logic                      has_pkt,
    output switch_pkg::level_t        level,
    output logic                      pause
);
    import switch_pkg::*;

    localparam int PTR_W = $clog2(`SW_FIFO_DEPTH);

    word_t            data_mem [`SW_FIFO_DEPTH];
    logic             eop_mem  [`SW_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    pkt_cnt_t         pkt_cnt;
    logic             in_pkt;    // Between a sop and its eop on the write side.
    logic             fifo_full;
    logic             wr_en;
    logic             rd_en;
    logic             pkt_inc;
    logic             pkt_dec;

    assign fifo_full = (level == level_t'(`SW_FIFO_DEPTH));

    // A word outside any packet frame, or one arriving at full depth, is dropped.
    assign wr_en = wr_vld && (wr_sop || in_pkt) && !fifo_full;
    assign rd_en = pop && (level != '0);

    assign pkt_inc = wr_en && wr_eop;
    assign pkt_dec = rd_en && head_eop;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= wr_data;
            eop_mem[wr_ptr]  <= wr_eop;
        end
    end

    // First word falls through so the arbiter can see the destination.
    assign head_word = data_mem[rd_ptr];
    assign head_eop  = eop_mem[rd_ptr];
    assign has_pkt   = (pkt_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            pkt_cnt <= '0;
            in_pkt  <= 1'b0;
            pause   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase

            case ({pkt_inc, pkt_dec})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase

            if (wr_vld) begin
                in_pkt <= !wr_eop && (wr_sop || in_pkt);  // Single-word packets never open a frame.
            end

            pause <= (level >= level_t'(`SW_PAUSE_LEVEL));
        end
    end

endmodule

`default_nettype wire

// File: switch_ctrl.sv
// Round-robin arbiter and transfer FSM that moves one packet at a time.
`timescale 1ns/1ps
`default_nettype none

`include "switch_macros.svh"

module switch_ctrl (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire switch_pkg::port_mask_t             wrr_en,
    input  wire switch_pkg::port_mask_t             ready,
    input  wire switch_pkg::port_mask_t             has_pkt,
    input  wire switch_pkg::port_t [`SW_PORTS-1:0]  head_dest,
    input  wire switch_pkg::port_mask_t             head_eop,
    output switch_pkg::port_mask_t                  pop,
    output switch_pkg::port_t                       sel_port,
    output switch_pkg::port_t                       dest_port,
    output logic                                    out_vld,
    output logic                                    out_sop,
    output logic                                    out_eop
);
    import switch_pkg::*;

    ctrl_state_t state;
    port_t       rr_ptr;      // Input with the highest priority at the next grant.
    port_mask_t  cand;
    logic        grant_vld;
    port_t       grant_port;
    logic        first_word;

    // Ready is looked at only here, when a packet is granted.
    always_comb begin
        for (int i = 0; i < `SW_PORTS; i++) begin
            cand[i] = has_pkt[i] && wrr_en[i] && ready[head_dest[i]];
        end
    end

    always_comb begin
        port_t idx;

        grant_vld  = 1'b0;
        grant_port = rr_ptr;
        for (int k = 0; k < `SW_PORTS; k++) begin
            idx = rr_ptr + port_t'(k);  // Wraps around the port count.
            if (!grant_vld && cand[idx]) begin
                grant_vld  = 1'b1;
                grant_port = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            rr_ptr     <= '0;
            sel_port   <= '0;
            dest_port  <= '0;
            first_word <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_vld) begin
                        state      <= SEND;
                        rr_ptr     <= grant_port + 1'b1;
                        sel_port   <= grant_port;
                        dest_port  <= head_dest[grant_port];
                        first_word <= 1'b1;
                    end
                end
                SEND: begin
                    first_word <= 1'b0;
                    if (head_eop[sel_port]) begin
                        state <= IDLE;  // Eop word leaves this cycle.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One word per SEND cycle, with strobes aligned to the popped word.
    always_comb begin
        pop     = '0;
        out_vld = (state == SEND);
        out_sop = (state == SEND) && first_word;
        out_eop = (state == SEND) && head_eop[sel_port];
        if (state == SEND) begin
            pop[sel_port] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: out_port_mux.sv
// Output datapath that registers the popped word onto its destination lane.
`timescale 1ns/1ps
`default_nettype none

`include "switch_macros.svh"

module out_port_mux (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire switch_pkg::word_t [`SW_PORTS-1:0]  head_word,
    input  wire switch_pkg::port_t                  sel_port,
    input  wire switch_pkg::port_t                  dest_port,
    input  wire                                     out_vld,
    input  wire                                     out_sop,
    input  wire                                     out_eop,
    output switch_pkg::port_mask_t                  rd_vld,
    output switch_pkg::port_mask_t                  rd_sop,
    output switch_pkg::port_mask_t                  rd_eop,
    output switch_pkg::word_t [`SW_PORTS-1:0]       rd_data
);
    import switch_pkg::*;

    port_mask_t lane;
    word_t      sel_word;

    assign lane     = port_mask_t'(1) << dest_port;  // One-hot destination lane.
    assign sel_word = head_word[sel_port];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_vld <= '0;
            rd_sop <= '0;
            rd_eop <= '0;
        end else begin
            rd_vld <= out_vld ? lane : '0;
            rd_sop <= out_sop ? lane : '0;
            rd_eop <= out_eop ? lane : '0;
        end
    end

    // Idle lanes keep their last word.
    always_ff @(posedge clk) begin
        if (out_vld) begin
            rd_data[dest_port] <= sel_word;
        end
    end

endmodule

`default_nettype wire

// File: switch_top.sv
// Top level of the 4-port packet switch with per-input FIFOs and one transfer path.
`timescale 1ns/1ps
`default_nettype none

`include "switch_macros.svh"

module switch_top (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire switch_pkg::port_mask_t             wr_sop,
    input  wire switch_pkg::port_mask_t             wr_eop,
    input  wire switch_pkg::port_mask_t             wr_vld,
    input  wire switch_pkg::word_t [`SW_PORTS-1:0]  wr_data,
    input  wire switch_pkg::port_mask_t             wrr_en,
    input  wire switch_pkg::port_mask_t             ready,
    output wire switch_pkg::port_mask_t             pause,
    output wire                                     full,
    output wire                                     almost_full,
    output wire switch_pkg::port_mask_t             rd_sop,
    output wire switch_pkg::port_mask_t             rd_eop,
    output wire switch_pkg::port_mask_t             rd_vld,
    output wire switch_pkg::word_t [`SW_PORTS-1:0]  rd_data
);
    import switch_pkg::*;

    wire word_t [`SW_PORTS-1:0] head_word;
    wire port_t [`SW_PORTS-1:0] head_dest;
    wire port_mask_t            head_eop;
    wire port_mask_t            has_pkt;
    wire port_mask_t            pop;
    wire port_mask_t            at_depth;
    wire level_t                level [`SW_PORTS];
    wire port_t                 sel_port;
    wire port_t                 dest_port;
    wire                        out_vld;
    wire                        out_sop;
    wire                        out_eop;

    for (genvar i = 0; i < `SW_PORTS; i++) begin : g_port
        in_port_fifo u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_vld    (wr_vld[i]),
            .wr_sop    (wr_sop[i]),
            .wr_eop    (wr_eop[i]),
            .wr_data   (wr_data[i]),
            .pop       (pop[i]),
            .head_word (head_word[i]),
            .head_eop  (head_eop[i]),
            .has_pkt   (has_pkt[i]),
            .level     (level[i]),
            .pause     (pause[i])
        );

        // Destination output sits in the low bits of the first word.
        assign head_dest[i] = head_word[i][`SW_PORT_BITS-1:0];
        assign at_depth[i]  = (level[i] == level_t'(`SW_FIFO_DEPTH));
    end

    switch_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .wrr_en    (wrr_en),
        .ready     (ready),
        .has_pkt   (has_pkt),
        .head_dest (head_dest),
        .head_eop  (head_eop),
        .pop       (pop),
        .sel_port  (sel_port),
        .dest_port (dest_port),
        .out_vld   (out_vld),
        .out_sop   (out_sop),
        .out_eop   (out_eop)
    );

    out_port_mux u_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_word (head_word),
        .sel_port  (sel_port),
        .dest_port (dest_port),
        .out_vld   (out_vld),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .rd_vld    (rd_vld),
        .rd_sop    (rd_sop),
        .rd_eop    (rd_eop),
        .rd_data   (rd_data)
    );

    assign full        = |at_depth;
    assign almost_full = |pause;  // Any input past its pause level.

endmodule

`default_nettype wire

// File: switch_assert.sv
// Bound checks on output framing, single-transfer lanes and flag consistency of the switch.
`timescale 1ns/1ps
`default_nettype none

module switch_assert (
    input wire                         clk,
    input wire                         rst_n,
    input wire switch_pkg::port_mask_t rd_vld,
    input wire switch_pkg::port_mask_t rd_sop,
    input wire switch_pkg::port_mask_t rd_eop,
    input wire switch_pkg::port_mask_t pause,
    input wire                         almost_full
);

    // Only one packet moves at a time.
    a_one_lane: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_vld))
        else $error("rd_vld has more than one active lane: %b", rd_vld);

    a_sop_vld: assert property (@(posedge clk) disable iff (!rst_n) (rd_sop & ~rd_vld) == '0)
        else $error("rd_sop without rd_vld on the same lane: %b", rd_sop);

    a_eop_vld: assert property (@(posedge clk) disable iff (!rst_n) (rd_eop & ~rd_vld) == '0)
        else $error("rd_eop without rd_vld on the same lane: %b", rd_eop);

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (rd_vld == '0))
        else $error("rd_vld active while in reset");

    a_almost_full: assert property (@(posedge clk) disable iff (!rst_n)
                                    almost_full == (|pause))
        else $error("almost_full does not follow pause");

endmodule

bind switch_top switch_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_vld      (rd_vld),
    .rd_sop      (rd_sop),
    .rd_eop      (rd_eop),
    .pause       (pause),
    .almost_full (almost_full)
);

`default_nettype wire

// File: switch_tb.sv
// Testbench for the 4-port packet switch with random traffic and a per-input queue model.
`timescale 1ns/1ps
`default_nettype none

`include "switch_macros.svh"

module switch_tb;
    import switch_pkg::*;

    localparam int N_RAND          = 60;
    localparam int N_DIRECTED      = 6;
    localparam int WATCHDOG_CYCLES = (N_RAND + N_DIRECTED) * (`SW_MAX_PKT + 20);

    logic                  clk;
    logic                  rst_n;
    port_mask_t            wr_sop;
    port_mask_t            wr_eop;
    port_mask_t            wr_vld;
    word_t [`SW_PORTS-1:0] wr_data;
    port_mask_t            wrr_en;
    port_mask_t            ready;
    port_mask_t            pause;
    logic                  full;
    logic                  almost_full;
    port_mask_t            rd_sop;
    port_mask_t            rd_eop;
    port_mask_t            rd_vld;
    word_t [`SW_PORTS-1:0] rd_data;

    integer     seed;
    int         value_errs = 0;
    int         other_errs = 0;
    logic       rand_flow  = 1'b0;
    port_t      cur_src    = '0;
    port_t      cur_dest   = '0;
    word_t      exp_word [`SW_PORTS][$];
    logic [1:0] exp_flag [`SW_PORTS][$];  // {sop, eop} for each expected word.

    switch_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .wrr_en      (wrr_en),
        .ready       (ready),
        .pause       (pause),
        .full        (full),
        .almost_full (almost_full),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    always #50 clk = ~clk;

    function automatic port_mask_t lane_mask(input port_t p);
        return port_mask_t'(1) << p;
    endfunction

    function automatic port_t first_lane(input port_mask_t m);
        port_t l;
        l = '0;
        for (int i = `SW_PORTS - 1; i >= 0; i--) begin
            if (m[i]) begin
                l = port_t'(i);
            end
        end
        return l;
    endfunction

    function automatic logic queues_empty();
        logic e;
        e = 1'b1;
        for (int p = 0; p < `SW_PORTS; p++) begin
            if (exp_word[p].size() != 0) begin
                e = 1'b0;
            end
        end
        return e;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            value_errs++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input port_t exp, input port_t act);
        if (exp !== act) begin
            value_errs++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t act);
        if (exp !== act) begin
            value_errs++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errs++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idle(input string phase);
        check_mask({phase, " rd_vld"}, '0, rd_vld);
        check_mask({phase, " rd_sop"}, '0, rd_sop);
        check_mask({phase, " rd_eop"}, '0, rd_eop);
        check_mask({phase, " pause"}, '0, pause);
        check_flag({phase, " full"}, 1'b0, full);
        check_flag({phase, " almost_full"}, 1'b0, almost_full);
    endtask

    // Called once per rising edge from the stimulus process.
    task automatic step_flow();
        logic [31:0] r;
        if (rand_flow) begin
            r = $random(seed);
            ready  <= r[3:0];
            wrr_en <= r[7:4] | r[11:8];  // Inputs are enabled three times out of four.
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            step_flow();
        end
    endtask

    task automatic wait_empty(input int max_cycles);
        int n;
        n = 0;
        while (!queues_empty() && n < max_cycles) begin
            @(posedge clk);
            step_flow();
            n++;
        end
    endtask

    task automatic send_pkt(input port_t src, input port_t dest, input int len);
        logic [31:0] r;
        word_t       w;
        @(negedge clk);
        while (pause[src]) begin
            @(posedge clk);
            step_flow();
            @(negedge clk);
        end
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            w = r[15:0];
            if (i == 0) begin
                w[3:2] = src;  // The model finds the source queue from this field.
                w[1:0] = dest;
            end
            @(posedge clk);
            step_flow();
            wr_vld[src]  <= 1'b1;
            wr_sop[src]  <= (i == 0);
            wr_eop[src]  <= (i == len - 1);
            wr_data[src] <= w;
            exp_word[src].push_back(w);
            exp_flag[src].push_back({i == 0, i == len - 1});
        end
        @(posedge clk);
        step_flow();
        wr_vld[src] <= 1'b0;
        wr_sop[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
    endtask

    task automatic send_random(input port_t src);
        logic [31:0] r;
        r = $random(seed);
        send_pkt(src, port_t'(r[1:0]), int'(r[4:2]) + 1);
    endtask

    task automatic finish_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Outputs are registered, so the falling edge sees settled values.
    always @(negedge clk) begin
        port_t      lane;
        word_t      w;
        logic [1:0] fl;
        if (rst_n && (rd_vld != '0)) begin
            lane = first_lane(rd_vld);
            if (rd_sop[lane]) begin
                cur_src = rd_data[lane][3:2];
            end
            if (exp_word[cur_src].size() == 0) begin
                other_errs++;
                $display("Word %h on output %0d but nothing is queued from input %0d",
                         rd_data[lane], lane, cur_src);
            end else begin
                w  = exp_word[cur_src].pop_front();
                fl = exp_flag[cur_src].pop_front();
                if (fl[1]) begin
                    cur_dest = w[1:0];
                end
                check_port("route", cur_dest, lane);
                check_word("data", w, rd_data[lane]);
                check_mask("rd_vld", lane_mask(cur_dest), rd_vld);
                check_mask("rd_sop", fl[1] ? lane_mask(cur_dest) : '0, rd_sop);
                check_mask("rd_eop", fl[0] ? lane_mask(cur_dest) : '0, rd_eop);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        other_errs++;
        $display("Watchdog expired after %0d cycles before traffic finished", WATCHDOG_CYCLES);
        finish_run();
    end

    initial begin
        logic [31:0] r;
        int          held;
        seed    = 32'h2285;
        clk     = 1'b0;
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        wrr_en  = '0;
        ready   = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        // Input 1 is masked while every output is ready.
        @(posedge clk);
        ready  <= '1;
        wrr_en <= 4'b1101;
        held = 0;
        for (int k = 0; k < 3; k++) begin
            r = $random(seed);
            send_pkt(port_t'(1), port_t'(r[1:0]), int'(r[4:2]) + 1);
            held += int'(r[4:2]) + 1;  // Every word written must still wait in the model.
        end
        idle(40);
        if (exp_word[1].size() != held) begin
            other_errs++;
            $display("Input 1 delivered packets while its enable bit was low");
        end
        wrr_en <= '1;
        wait_empty(200);
        if (!queues_empty()) begin
            other_errs++;
            $display("Input 1 packets were not delivered after its enable bit was set");
        end

        // No output ready, so input 2 fills up to the pause level.
        @(posedge clk);
        ready <= '0;
        for (int k = 1; k <= 3; k++) begin
            r = $random(seed);
            send_pkt(port_t'(2), port_t'(r[1:0]), `SW_MAX_PKT);
            idle(2);
            @(negedge clk);
            check_mask("pause level", (k * `SW_MAX_PKT >= `SW_PAUSE_LEVEL) ?
                       lane_mask(port_t'(2)) : '0, pause);
            check_flag("almost_full level", k * `SW_MAX_PKT >= `SW_PAUSE_LEVEL, almost_full);
            check_flag("full level", 1'b0, full);
        end
        @(posedge clk);
        ready <= '1;
        wait_empty(200);
        idle(3);
        @(negedge clk);
        check_mask("pause after drain", '0, pause);
        check_flag("almost_full after drain", 1'b0, almost_full);

        rand_flow = 1'b1;
        for (int k = 0; k < N_RAND; k++) begin
            r = $random(seed);
            send_random(port_t'(r[1:0]));
        end
        rand_flow = 1'b0;
        @(posedge clk);
        ready  <= '1;
        wrr_en <= '1;
        wait_empty(N_RAND * (`SW_MAX_PKT + 4));
        idle(2);

        for (int p = 0; p < `SW_PORTS; p++) begin
            if (exp_word[p].size() != 0) begin
                other_errs++;
                $display("Input %0d still holds %0d words that never reached an output",
                         p, exp_word[p].size());
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
switch_pkg.sv
in_port_fifo.sv
switch_ctrl.sv
out_port_mux.sv
switch_top.sv
switch_assert.sv
switch_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := switch_tb
FILELIST   := files.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
